// File: rtl/ciDefines_defines.svh
`ifndef CI_DEFINES_SVH
`define CI_DEFINES_SVH

// Operand and result width.
`define CI_WORD_WIDTH 32
`define CI_ID_WIDTH 8

// Instruction numbers owned by the units.
`define CI_ID_SWAP 8'd1
`define CI_ID_DELAY 8'd6

// 25 MHz system clock.
`define CLOCK_TICKS_PER_MICRO 25

// Top bit of the counter ends the reset, 16 cycles after lock.
`define RESET_STRETCH_BITS 5

// Answer for a number that no unit owns.
`define CI_ILLEGAL_RESULT {`CI_WORD_WIDTH{1'b1}}

`endif

// File: rtl/ciPkg.sv
`include "ciDefines_defines.svh"

package ciPkg;

  // Operand or result word.
  typedef logic [`CI_WORD_WIDTH-1:0] ciWord_t;

  // Custom instruction number.
  typedef logic [`CI_ID_WIDTH-1:0] ciId_t;

  // Byte-swap mode, taken from the low bits of operand B.
  typedef logic [1:0] swapMode_t;

  // Request side handshake.
  typedef enum logic [1:0] {
    idle,
    issue,
    waitAck
  } requestState_t;

  // Response side handshake.
  typedef enum logic {
    collect,
    acknowledge
  } responseState_t;

endpackage

// File: rtl/resetSequencer.sv
`timescale 1ns/1ps
`include "ciDefines_defines.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset
);

  logic [`RESET_STRETCH_BITS-1:0] stretchCount;

  // Count after lock until the top bit sets, then hold.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      stretchCount <= '0;
    end else if (!stretchCount[`RESET_STRETCH_BITS-1]) begin
      stretchCount <= stretchCount + 1'b1;
    end
  end

  assign systemReset = ~stretchCount[`RESET_STRETCH_BITS-1];

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !systemReset |=> !systemReset)
    else $error("Internal reset came back while the PLL stayed locked.");

endmodule

// File: rtl/ciRequestPort.sv
`timescale 1ns/1ps
`include "ciDefines_defines.svh"

module ciRequestPort (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  logic           systemReset,
  input  logic           ciReq,
  input  ciPkg::ciId_t   ciN,
  input  ciPkg::ciWord_t ciDataA,
  input  ciPkg::ciWord_t ciDataB,
  input  logic           ciAck,
  output ciPkg::ciWord_t opA,
  output ciPkg::ciWord_t opB,
  output logic           swapStart,
  output logic           delayStart,
  output logic           illegalStart
);

  ciPkg::requestState_t state;
  logic accept;
  logic isSwap;
  logic isDelay;

  assign accept  = (state == ciPkg::idle) && ciReq;
  assign isSwap  = (ciN == `CI_ID_SWAP);
  assign isDelay = (ciN == `CI_ID_DELAY);

  // The number is decoded here once; the units only see their start pulse.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state        <= ciPkg::idle;
      swapStart    <= 1'b0;
      delayStart   <= 1'b0;
      illegalStart <= 1'b0;
    end else if (systemReset) begin
      state        <= ciPkg::idle;
      swapStart    <= 1'b0;
      delayStart   <= 1'b0;
      illegalStart <= 1'b0;
    end else begin
      swapStart    <= 1'b0;
      delayStart   <= 1'b0;
      illegalStart <= 1'b0;
      case (state)
        ciPkg::idle: begin
          if (accept) begin
            state        <= ciPkg::issue;
            swapStart    <= isSwap;
            delayStart   <= isDelay;
            illegalStart <= !(isSwap || isDelay);
          end
        end
        ciPkg::issue: begin
          state <= ciPkg::waitAck;
        end
        ciPkg::waitAck: begin
          // Host has seen the ack and dropped its request.
          if (ciAck && !ciReq) begin
            state <= ciPkg::idle;
          end
        end
        default: begin
          state <= ciPkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (accept) begin
      opA <= ciDataA;
      opB <= ciDataB;
    end
  end

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    $onehot0({swapStart, delayStart, illegalStart}))
    else $error("More than one unit started at once.");

endmodule

// File: rtl/byteSwapUnit.sv
`timescale 1ns/1ps

module byteSwapUnit (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  logic           systemReset,
  input  logic           start,
  input  ciPkg::ciWord_t opA,
  input  ciPkg::ciWord_t opB,
  output logic           done,
  output ciPkg::ciWord_t result
);

  ciPkg::swapMode_t mode;
  ciPkg::ciWord_t swapped;

  assign mode = opB[1:0];

  always_comb begin
    case (mode)
      2'd0: swapped = {opA[7:0], opA[15:8], opA[23:16], opA[31:24]};
      2'd1: swapped = {opA[23:16], opA[31:24], opA[7:0], opA[15:8]};
      2'd2: swapped = {opA[15:0], opA[31:16]};
      default: swapped = opA;
    endcase
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      done <= 1'b0;
    end else if (systemReset) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // Zero outside the done cycle, so it can be ORed with the other units.
  always_ff @(posedge s_systemClock) begin
    result <= start ? swapped : '0;
  end

endmodule

// File: rtl/microDelayUnit.sv
`timescale 1ns/1ps
`include "ciDefines_defines.svh"

module microDelayUnit (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  logic           systemReset,
  input  logic           start,
  input  ciPkg::ciWord_t opA,
  output logic           done,
  output ciPkg::ciWord_t result
);

  localparam int unsigned PRESCALE_BITS = $clog2(`CLOCK_TICKS_PER_MICRO);

  logic [PRESCALE_BITS-1:0] prescale;
  ciPkg::ciWord_t microCount;
  logic busy;
  logic microTick;

  assign microTick = (prescale == PRESCALE_BITS'(`CLOCK_TICKS_PER_MICRO - 1));

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busy       <= 1'b0;
      done       <= 1'b0;
      prescale   <= '0;
      microCount <= '0;
    end else if (systemReset) begin
      busy       <= 1'b0;
      done       <= 1'b0;
      prescale   <= '0;
      microCount <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        prescale   <= '0;
        microCount <= opA;
        // A zero delay answers on the next cycle.
        busy       <= (opA != '0);
        done       <= (opA == '0);
      end else if (busy) begin
        if (microTick) begin
          prescale   <= '0;
          microCount <= microCount - 1'b1;
          if (microCount == ciPkg::ciWord_t'(1)) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end else begin
          prescale <= prescale + 1'b1;
        end
      end
    end
  end

  // The delay returns no value.
  assign result = '0;

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked || systemReset)
    start |-> !busy)
    else $error("Delay started while a delay was still running.");

endmodule

// File: rtl/ciResponsePort.sv
`timescale 1ns/1ps
`include "ciDefines_defines.svh"

module ciResponsePort (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  logic           systemReset,
  input  logic           swapDone,
  input  logic           delayDone,
  input  logic           illegalStart,
  input  ciPkg::ciWord_t swapResult,
  input  ciPkg::ciWord_t delayResult,
  input  logic           ciReq,
  output logic           ciAck,
  output ciPkg::ciWord_t ciResult
);

  ciPkg::responseState_t state;
  logic illegalDone;
  logic anyDone;
  ciPkg::ciWord_t anyResult;

  // Units answer with zero when idle, so a plain OR collects them.
  assign anyDone   = swapDone | delayDone | illegalDone;
  assign anyResult = swapResult | delayResult | (illegalDone ? `CI_ILLEGAL_RESULT : '0);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state       <= ciPkg::collect;
      illegalDone <= 1'b0;
    end else if (systemReset) begin
      state       <= ciPkg::collect;
      illegalDone <= 1'b0;
    end else begin
      // Same one-cycle latency as the swap unit.
      illegalDone <= illegalStart;
      case (state)
        ciPkg::collect:     if (anyDone) state <= ciPkg::acknowledge;
        ciPkg::acknowledge: if (!ciReq) state <= ciPkg::collect;
        default:            state <= ciPkg::collect;
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (state == ciPkg::collect && anyDone) begin
      ciResult <= anyResult;
    end
  end

  assign ciAck = (state == ciPkg::acknowledge);

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    ciAck ##1 ciAck |-> $stable(ciResult))
    else $error("Result changed while acknowledged.");

endmodule

// File: rtl/ciHub.sv
`timescale 1ns/1ps

module ciHub (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  logic           ciReq,
  input  ciPkg::ciId_t   ciN,
  input  ciPkg::ciWord_t ciDataA,
  input  ciPkg::ciWord_t ciDataB,
  output logic           ciAck,
  output ciPkg::ciWord_t ciResult
);

  logic systemReset;
  ciPkg::ciWord_t opA;
  ciPkg::ciWord_t opB;
  logic swapStart;
  logic delayStart;
  logic illegalStart;
  logic swapDone;
  logic delayDone;
  ciPkg::ciWord_t swapResult;
  ciPkg::ciWord_t delayResult;

  resetSequencer i_resetSequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReset  (systemReset)
  );

  ciRequestPort i_ciRequestPort (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReset  (systemReset),
    .ciReq        (ciReq),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .ciAck        (ciAck),
    .opA          (opA),
    .opB          (opB),
    .swapStart    (swapStart),
    .delayStart   (delayStart),
    .illegalStart (illegalStart)
  );

  byteSwapUnit i_byteSwapUnit (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReset  (systemReset),
    .start        (swapStart),
    .opA          (opA),
    .opB          (opB),
    .done         (swapDone),
    .result       (swapResult)
  );

  microDelayUnit i_microDelayUnit (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReset  (systemReset),
    .start        (delayStart),
    .opA          (opA),
    .done         (delayDone),
    .result       (delayResult)
  );

  ciResponsePort i_ciResponsePort (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReset  (systemReset),
    .swapDone     (swapDone),
    .delayDone    (delayDone),
    .illegalStart (illegalStart),
    .swapResult   (swapResult),
    .delayResult  (delayResult),
    .ciReq        (ciReq),
    .ciAck        (ciAck),
    .ciResult     (ciResult)
  );

endmodule

// File: sim/ciHubTb.sv
`timescale 1ns/1ps
`include "ciDefines_defines.svh"

module ciHubTb;

  localparam int RESET_CYCLES = 4;
  // Internal reset length after lock, and system clocks per microsecond at 25 MHz.
  localparam int STRETCH_CYCLES = 16;
  localparam int TICKS = 25;
  localparam int RANDOM_COUNT = 20;
  localparam int MAX_RANDOM_MICROS = 2;
  localparam int BACKPRESSURE_CYCLES = 10;
  localparam int NUM_REQUESTS = 1 + 4 + 3 + 1 + 1 + RANDOM_COUNT;
  // Drive edge, drop edge, fall edge and the gap before the next request.
  localparam int REQUEST_OVERHEAD = 4;
  localparam int TIMEOUT_MARGIN = 100;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + STRETCH_CYCLES
    + NUM_REQUESTS * (3 + REQUEST_OVERHEAD)
    + (0 + 1 + 3 + RANDOM_COUNT * MAX_RANDOM_MICROS) * TICKS
    + BACKPRESSURE_CYCLES + TIMEOUT_MARGIN;

  logic           s_systemClock;
  logic           s_pllLocked;
  logic           ciReq;
  ciPkg::ciId_t   ciN;
  ciPkg::ciWord_t ciDataA;
  ciPkg::ciWord_t ciDataB;
  logic           ciAck;
  ciPkg::ciWord_t ciResult;

  integer seed;
  int errorCount = 0;
  int checkCount = 0;
  int errorsAtStart = 0;
  int cycleCount = 0;

  // Responses waiting for the comparing process.
  ciPkg::ciId_t   respId[$];
  ciPkg::ciWord_t respA[$];
  ciPkg::ciWord_t respB[$];
  ciPkg::ciWord_t respResult[$];
  int             respLatency[$];
  int             respHoldOff[$];

  ciHub i_ciHub (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciReq        (ciReq),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .ciAck        (ciAck),
    .ciResult     (ciResult)
  );

  always #20 s_systemClock = ~s_systemClock;

  // Latency counts rising edges from the one that drives the request to the one after
  // which ack is high.
  function automatic void expectedResponse(input ciPkg::ciId_t id, input ciPkg::ciWord_t a,
                                           input ciPkg::ciWord_t b,
                                           output ciPkg::ciWord_t result, output int latency);
    int mask;
    result = '0;
    latency = 3;
    if (id == `CI_ID_SWAP) begin
      // Byte i of the result comes from byte i xor mask of operand A.
      case (b[1:0])
        2'd0: mask = 3;
        2'd1: mask = 1;
        2'd2: mask = 2;
        default: mask = 0;
      endcase
      for (int i = 0; i < 4; i++) begin
        result[8*i +: 8] = a[8*(i ^ mask) +: 8];
      end
    end else if (id == `CI_ID_DELAY) begin
      latency = 3 + int'(a) * TICKS;
    end else begin
      result = '1;
    end
  endfunction

  task automatic runRequest(input ciPkg::ciId_t id, input ciPkg::ciWord_t a,
                            input ciPkg::ciWord_t b, input int holdOff, input int extraHold);
    int cycles;
    logic ackSeen;
    ciPkg::ciWord_t heldResult;
    @(posedge s_systemClock);
    ciN     <= id;
    ciDataA <= a;
    ciDataB <= b;
    ciReq   <= 1'b1;
    cycles = 0;
    ackSeen = 1'b0;
    while (!ackSeen) begin
      @(posedge s_systemClock);
      cycles++;
      @(negedge s_systemClock);
      ackSeen = ciAck;
    end
    heldResult = ciResult;
    respId.push_back(id);
    respA.push_back(a);
    respB.push_back(b);
    respResult.push_back(heldResult);
    respLatency.push_back(cycles);
    respHoldOff.push_back(holdOff);
    repeat (extraHold) begin
      @(negedge s_systemClock);
      checkCount++;
      assert (ciAck && ciResult == heldResult) else begin
        $display("FAIL %0t: ack %b result %h moved while request held, expected 1 %h",
                 $time, ciAck, ciResult, heldResult);
        errorCount++;
      end
    end
    @(posedge s_systemClock);
    ciReq <= 1'b0;
    @(negedge s_systemClock);
    checkCount++;
    assert (ciAck) else begin
      $display("FAIL %0t: ack fell in the same cycle as the request", $time);
      errorCount++;
    end
    @(negedge s_systemClock);
    checkCount++;
    assert (!ciAck) else begin
      $display("FAIL %0t: ack still high one cycle after the request fell", $time);
      errorCount++;
    end
  endtask

  task automatic finishTest(input string name);
    while (respId.size() != 0) begin
      @(negedge s_systemClock);
    end
    $display("%s: %0d errors", name, errorCount - errorsAtStart);
    errorsAtStart = errorCount;
  endtask

  always @(negedge s_systemClock) begin : compareResponses
    ciPkg::ciId_t id;
    ciPkg::ciWord_t a;
    ciPkg::ciWord_t b;
    ciPkg::ciWord_t got;
    ciPkg::ciWord_t expResult;
    int gotLatency;
    int expLatency;
    if (respId.size() != 0) begin
      id = respId.pop_front();
      a = respA.pop_front();
      b = respB.pop_front();
      got = respResult.pop_front();
      gotLatency = respLatency.pop_front();
      expectedResponse(id, a, b, expResult, expLatency);
      expLatency = expLatency + respHoldOff.pop_front();
      checkCount += 2;
      assert (got == expResult) else begin
        $display("FAIL %0t: ciN %0d A %h B %h gave %h, expected %h",
                 $time, id, a, b, got, expResult);
        errorCount++;
      end
      assert (gotLatency == expLatency) else begin
        $display("FAIL %0t: ciN %0d A %h took %0d cycles, expected %0d",
                 $time, id, a, gotLatency, expLatency);
        errorCount++;
      end
    end
  end

  always @(posedge s_systemClock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    int kind;
    int rnd;
    ciPkg::ciId_t id;
    ciPkg::ciWord_t a;
    s_systemClock = 1'b0;
    // Start locked so the first drop is a real edge.
    s_pllLocked = 1'b1;
    ciReq = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    seed = 32'hf87c5e86;

    @(posedge s_systemClock);
    s_pllLocked <= 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge s_systemClock);
      checkCount++;
      assert (!ciAck) else begin
        $display("FAIL %0t: ack high while the PLL is unlocked", $time);
        errorCount++;
      end
    end
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    // Request driven one edge after lock waits for the rest of the stretch.
    runRequest(`CI_ID_SWAP, $random(seed), 32'd0, STRETCH_CYCLES - 1, 0);
    finishTest("reset hold-off");

    for (int mode = 0; mode < 4; mode++) begin
      rnd = $random(seed);
      runRequest(`CI_ID_SWAP, $random(seed), {rnd[31:2], mode[1:0]}, 0, 0);
    end
    finishTest("byte swap modes");

    runRequest(`CI_ID_DELAY, 32'd0, $random(seed), 0, 0);
    runRequest(`CI_ID_DELAY, 32'd1, $random(seed), 0, 0);
    runRequest(`CI_ID_DELAY, 32'd3, $random(seed), 0, 0);
    finishTest("microsecond delay");

    runRequest(8'd9, $random(seed), $random(seed), 0, 0);
    finishTest("illegal number");

    runRequest(`CI_ID_SWAP, $random(seed), $random(seed), 0, BACKPRESSURE_CYCLES);
    finishTest("back-pressure");

    for (int n = 0; n < RANDOM_COUNT; n++) begin
      kind = {$random(seed)} % 3;
      rnd = $random(seed);
      case (kind)
        0: begin
          id = `CI_ID_SWAP;
          a = $random(seed);
        end
        1: begin
          id = `CI_ID_DELAY;
          a = {$random(seed)} % (MAX_RANDOM_MICROS + 1);
        end
        default: begin
          id = rnd[7:0];
          if (id == `CI_ID_SWAP || id == `CI_ID_DELAY) begin
            id = id + 8'd2;
          end
          a = $random(seed);
        end
      endcase
      runRequest(id, a, $random(seed), 0, 0);
    end
    finishTest("random mix");

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
rtl/ciPkg.sv
rtl/resetSequencer.sv
rtl/ciRequestPort.sv
rtl/byteSwapUnit.sv
rtl/microDelayUnit.sv
rtl/ciResponsePort.sv
rtl/ciHub.sv
sim/ciHubTb.sv

// File: Makefile
# Verilator build and run for the custom-instruction hub testbench.

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module ciHubTb -Mdir obj_dir -o ciHubTb

run: compile
	./obj_dir/ciHubTb | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation reported failures"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
